// File: hw/rv_pkg.sv
/*
 * shared RV32I execute definitions.
 * encodings of alu_op_e and the select enums are fixed; other blocks rely on them.
 */
`default_nettype none

package rv_pkg;

	// register index width, 32 architectural registers
	localparam int unsigned REG_IDX_W = 5;

	// alu operations, ordered like the funct3 groups
	typedef enum logic [3:0] {
		ALU_ADD   = 4'b0000,
		ALU_SUB   = 4'b0001,
		ALU_SLL   = 4'b0010,
		ALU_SLT   = 4'b0011,
		ALU_SLTU  = 4'b0100,
		ALU_XOR   = 4'b0101,
		ALU_SRL   = 4'b0110,
		ALU_SRA   = 4'b0111,
		ALU_OR    = 4'b1000,
		ALU_AND   = 4'b1001,
		// source 2 straight through, used by lui
		ALU_PASS2 = 4'b1010
	} alu_op_e;

	// first alu operand
	typedef enum logic [1:0] {
		SRC1_ZERO = 2'b00,
		SRC1_REG  = 2'b01,
		SRC1_PC   = 2'b10
	} src1_sel_e;

	// second alu operand
	typedef enum logic [1:0] {
		SRC2_REG  = 2'b00,
		SRC2_IMM  = 2'b01,
		SRC2_PC   = 2'b10,
		SRC2_ZERO = 2'b11
	} src2_sel_e;

	// major opcodes handled here
	typedef enum logic [6:0] {
		OP     = 7'b0110011,
		OP_IMM = 7'b0010011,
		LUI    = 7'b0110111,
		AUIPC  = 7'b0010111
	} opcode_e;

endpackage

`default_nettype wire

// File: hw/exe_ctrl_if.sv
/*
 * decoded controls, decoder to execute stage.
 * all signals are combinational; the decoder drives every one of them.
 */
`default_nettype none

interface exe_ctrl_if;
	import rv_pkg::*;

	alu_op_e              alu_op;
	src1_sel_e            src1_sel;
	src2_sel_e            src2_sel;
	// sign extended i-type or u-type value
	logic [31:0]          imm;
	// write enable, already gated with valid
	logic                 wd;
	logic [REG_IDX_W-1:0] wreg;

	modport decoder (output alu_op, output src1_sel, output src2_sel,
		output imm, output wd, output wreg);

	modport execute (input alu_op, input src1_sel, input src2_sel,
		input imm, input wd, input wreg);

endinterface

`default_nettype wire

// File: hw/rv_alu.sv
/*
 * combinational RV32I alu.
 * shift amounts use src2[4:0] only; compares return 0 or 1.
 */
`default_nettype none

module rv_alu (
	input  logic [31:0]     src1_i,
	input  logic [31:0]     src2_i,
	input  rv_pkg::alu_op_e alu_op_i,
	output logic [31:0]     result_o
);
	import rv_pkg::*;

	logic [4:0]  shamt;
	logic        lt_signed;
	logic        lt_unsigned;

	// shift amount from the low bits
	assign shamt = src2_i[4:0];

	// compare results
	assign lt_signed   = $signed(src1_i) < $signed(src2_i);
	assign lt_unsigned = src1_i < src2_i;

	always_comb begin
		case (alu_op_i)
			ALU_ADD:   result_o = src1_i + src2_i;
			ALU_SUB:   result_o = src1_i - src2_i;
			ALU_SLL:   result_o = src1_i << shamt;
			ALU_SLT:   result_o = {31'b0, lt_signed};
			ALU_SLTU:  result_o = {31'b0, lt_unsigned};
			ALU_XOR:   result_o = src1_i ^ src2_i;
			ALU_SRL:   result_o = src1_i >> shamt;
			// arithmetic, fills with the sign bit
			ALU_SRA:   result_o = $unsigned($signed(src1_i) >>> shamt);
			ALU_OR:    result_o = src1_i | src2_i;
			ALU_AND:   result_o = src1_i & src2_i;
			// lui style pass
			ALU_PASS2: result_o = src2_i;
			// unused encodings
			default:   result_o = 32'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_decoder.sv
/*
 * RV32I decoder for OP, OP-IMM, LUI and AUIPC only.
 * any other opcode is a no-op with the write enable low.
 * funct7 is only looked at through bit 30; other funct7 bits are not checked.
 */
`default_nettype none

module rv_decoder (
	input  logic                         valid_i,
	input  logic [31:0]                  inst_i,
	output logic [rv_pkg::REG_IDX_W-1:0] rs1_o,
	output logic [rv_pkg::REG_IDX_W-1:0] rs2_o,
	exe_ctrl_if.decoder                  ctrl
);
	import rv_pkg::*;

	opcode_e     opcode;
	logic [2:0]  funct3;
	// selects sub and sra
	logic        funct7_b5;
	logic [31:0] imm_i_type;
	logic [31:0] imm_u_type;

	// funct3 to alu operation for both OP and OP-IMM
	function automatic alu_op_e funct3_op(input logic [2:0] f3, input logic alt);
		alu_op_e op;
		case (f3)
			3'b000:  op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  op = ALU_SLL;
			3'b010:  op = ALU_SLT;
			3'b011:  op = ALU_SLTU;
			3'b100:  op = ALU_XOR;
			3'b101:  op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  op = ALU_OR;
			default: op = ALU_AND;
		endcase
		return op;
	endfunction

	// instruction fields
	assign opcode    = opcode_e'(inst_i[6:0]);
	assign funct3    = inst_i[14:12];
	assign funct7_b5 = inst_i[30];
	assign rs1_o     = inst_i[19:15];
	assign rs2_o     = inst_i[24:20];

	// i-type sign extended from bit 31
	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	// u-type with the low 12 bits zero
	assign imm_u_type = {inst_i[31:12], 12'b0};

	// destination index always taken from the rd field
	assign ctrl.wreg = inst_i[11:7];

	always_comb begin
		// defaults describe the no-op
		ctrl.alu_op   = ALU_ADD;
		ctrl.src1_sel = SRC1_ZERO;
		ctrl.src2_sel = SRC2_ZERO;
		ctrl.imm      = imm_i_type;
		ctrl.wd       = 1'b0;
		case (opcode)
			OP: begin
				// bit 30 picks sub and sra
				ctrl.alu_op   = funct3_op(funct3, funct7_b5);
				ctrl.src1_sel = SRC1_REG;
				ctrl.src2_sel = SRC2_REG;
				ctrl.wd       = valid_i;
			end
			OP_IMM: begin
				// addi has no sub form so bit 30 only selects srai
				ctrl.alu_op   = funct3_op(funct3, (funct3 == 3'b101) && funct7_b5);
				ctrl.src1_sel = SRC1_REG;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.wd       = valid_i;
			end
			LUI: begin
				// result is the immediate itself
				ctrl.alu_op   = ALU_PASS2;
				ctrl.src1_sel = SRC1_ZERO;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.imm      = imm_u_type;
				ctrl.wd       = valid_i;
			end
			AUIPC: begin
				// pc plus immediate
				ctrl.alu_op   = ALU_ADD;
				ctrl.src1_sel = SRC1_PC;
				ctrl.src2_sel = SRC2_IMM;
				ctrl.imm      = imm_u_type;
				ctrl.wd       = valid_i;
			end
			default: begin
				// unsupported opcodes never write
				ctrl.wd = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// File: hw/rv_regfile.sv
/*
 * 32x32 register file, two async read ports and one write port.
 * x0 reads zero and ignores writes. no bypass: a write lands on the clock edge.
 */
`default_nettype none

module rv_regfile (
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic [rv_pkg::REG_IDX_W-1:0] rs1_i,
	input  logic [rv_pkg::REG_IDX_W-1:0] rs2_i,
	output logic [31:0]                  rdata1_o,
	output logic [31:0]                  rdata2_o,
	input  logic                         we_i,
	input  logic [rv_pkg::REG_IDX_W-1:0] waddr_i,
	input  logic [31:0]                  wdata_i
);
	import rv_pkg::*;

	// x1..x31 only, x0 has no storage
	logic [31:0] regs [1:(2**REG_IDX_W)-1];

	always_ff @(posedge clk_i) begin
		if (reset_i) begin
			// clear the whole file on reset
			for (int i = 1; i < 2**REG_IDX_W; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// combinational reads
	// x0 forced to zero
	assign rdata1_o = (rs1_i == '0) ? 32'b0 : regs[rs1_i];
	assign rdata2_o = (rs2_i == '0) ? 32'b0 : regs[rs2_i];

endmodule

`default_nettype wire

// File: hw/rv_exe.sv
/*
 * execute stage: operand selection in front of the alu.
 * purely combinational; write-back fields pass through from the decoder.
 */
`default_nettype none

module rv_exe (
	input  logic [31:0]                  reg1_i,
	input  logic [31:0]                  reg2_i,
	input  logic [31:0]                  pc_i,
	exe_ctrl_if.execute                  ctrl,
	output logic                         wd_o,
	output logic [rv_pkg::REG_IDX_W-1:0] wreg_o,
	output logic [31:0]                  wdata_o
);
	import rv_pkg::*;

	logic [31:0] src1;
	logic [31:0] src2;

	// source 1 mux, unused key gives zero
	always_comb begin
		case (ctrl.src1_sel)
			SRC1_REG: src1 = reg1_i;
			SRC1_PC:  src1 = pc_i;
			default:  src1 = 32'b0;
		endcase
	end

	// source 2 mux
	always_comb begin
		case (ctrl.src2_sel)
			SRC2_REG: src2 = reg2_i;
			SRC2_IMM: src2 = ctrl.imm;
			SRC2_PC:  src2 = pc_i;
			default:  src2 = 32'b0;
		endcase
	end

	rv_alu u_alu (
		.src1_i   (src1),
		.src2_i   (src2),
		.alu_op_i (ctrl.alu_op),
		.result_o (wdata_o)
	);

	// write-back intent travels with the result
	assign wd_o   = ctrl.wd;
	assign wreg_o = ctrl.wreg;

endmodule

`default_nettype wire

// File: hw/rv_exec_top.sv
/*
 * single-cycle RV32I integer execute datapath.
 * inst/pc/valid to wd/wreg/wdata is combinational; register write on next clk_i edge.
 * keep valid_i low during reset. no back-pressure.
 */
`default_nettype none

module rv_exec_top (
	input  logic                         clk_i,
	input  logic                         reset_i,
	input  logic                         valid_i,
	input  logic [31:0]                  inst_i,
	input  logic [31:0]                  pc_i,
	output logic                         wd_o,
	output logic [rv_pkg::REG_IDX_W-1:0] wreg_o,
	output logic [31:0]                  wdata_o
);
	import rv_pkg::*;

	// source register indexes
	logic [REG_IDX_W-1:0] rs1;
	logic [REG_IDX_W-1:0] rs2;
	// operand values
	logic [31:0]          rdata1;
	logic [31:0]          rdata2;

	// decoder to execute controls
	exe_ctrl_if ctrl_if ();

	rv_decoder u_decoder (
		.valid_i (valid_i),
		.inst_i  (inst_i),
		.rs1_o   (rs1),
		.rs2_o   (rs2),
		.ctrl    (ctrl_if.decoder)
	);

	// write port fed straight from the execute outputs
	rv_regfile u_regfile (
		.clk_i    (clk_i),
		.reset_i  (reset_i),
		.rs1_i    (rs1),
		.rs2_i    (rs2),
		.rdata1_o (rdata1),
		.rdata2_o (rdata2),
		.we_i     (wd_o),
		.waddr_i  (wreg_o),
		.wdata_i  (wdata_o)
	);

	rv_exe u_exe (
		.reg1_i  (rdata1),
		.reg2_i  (rdata2),
		.pc_i    (pc_i),
		.ctrl    (ctrl_if.execute),
		.wd_o    (wd_o),
		.wreg_o  (wreg_o),
		.wdata_o (wdata_o)
	);

endmodule

`default_nettype wire

// File: test/rv_exec_checker.sv
/*
 * port-level checks bound onto rv_exec_top, sampled on the rising clk_i edge.
 * failed checks are counted in failures for the testbench to read.
 */
`default_nettype none

module rv_exec_checker (
	input logic        clk_i,
	input logic        reset_i,
	input logic        valid_i,
	input logic [31:0] inst_i,
	input logic        wd_o
);
	timeunit 1ns;
	timeprecision 100ps;

	import rv_pkg::*;

	int unsigned failures = 0;

	// nothing written while in reset
	reset_no_write: assert property (@(posedge clk_i) reset_i |-> !wd_o)
		else begin
			$error("wd_o high during reset");
			failures++;
		end

	// idle cycles never write
	idle_no_write: assert property (@(posedge clk_i) !valid_i |-> !wd_o)
		else begin
			$error("wd_o high while valid_i is low");
			failures++;
		end

	// unknown opcodes decode as no-ops
	unsupported_no_write: assert property (@(posedge clk_i)
		(valid_i && !(inst_i[6:0] inside {OP, OP_IMM, LUI, AUIPC})) |-> !wd_o)
		else begin
			$error("wd_o high for an unsupported opcode");
			failures++;
		end

	// every valid supported instruction retires
	supported_writes: assert property (@(posedge clk_i) disable iff (reset_i)
		(valid_i && (inst_i[6:0] inside {OP, OP_IMM, LUI, AUIPC})) |-> wd_o)
		else begin
			$error("wd_o low for a valid supported instruction");
			failures++;
		end

endmodule

bind rv_exec_top rv_exec_checker u_checker (
	.clk_i   (clk_i),
	.reset_i (reset_i),
	.valid_i (valid_i),
	.inst_i  (inst_i),
	.wd_o    (wd_o)
);

`default_nettype wire

// File: test/rv_exec_tb.sv
/*
 * testbench for rv_exec_top. random OP, OP-IMM, LUI and AUIPC streams run against
 * a model register file. outputs are checked at the falling edge.
 * the run stops at the first mismatch. the xorshift seed is fixed.
 */
`default_nettype none

module rv_exec_tb;
	timeunit 1ns;
	timeprecision 100ps;

	import rv_pkg::*;

	localparam int CLK_PERIOD  = 8;
	localparam int SEED_COUNT  = 31;
	localparam int OP_COUNT    = 200;
	localparam int IMM_COUNT   = 200;
	localparam int CHAIN_COUNT = 40;
	localparam int MISC_COUNT  = 6;
	localparam int NUM_INST    = SEED_COUNT + OP_COUNT + IMM_COUNT + CHAIN_COUNT + MISC_COUNT;
	// reset cycles plus one cycle per instruction plus a margin
	localparam int WATCHDOG_NS = (5 + NUM_INST + 20) * CLK_PERIOD;

	logic                 clk_i;
	logic                 reset_i;
	logic                 valid_i;
	logic [31:0]          inst_i;
	logic [31:0]          pc_i;
	logic                 wd_o;
	logic [REG_IDX_W-1:0] wreg_o;
	logic [31:0]          wdata_o;

	// expected architectural state where x0 is never written
	logic [31:0] model_regs [32];
	logic [31:0] rng_state = 32'd87103;

	rv_exec_top UUT (
		.clk_i   (clk_i),
		.reset_i (reset_i),
		.valid_i (valid_i),
		.inst_i  (inst_i),
		.pc_i    (pc_i),
		.wd_o    (wd_o),
		.wreg_o  (wreg_o),
		.wdata_o (wdata_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	// xorshift32
	function automatic logic [31:0] next_rand();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// instruction assembly
	function automatic logic [31:0] op_inst(input logic [6:0] f7, input logic [4:0] rs2,
		input logic [4:0] rs1, input logic [2:0] f3, input logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, OP};
	endfunction

	function automatic logic [31:0] imm_inst(input logic [11:0] imm, input logic [4:0] rs1,
		input logic [2:0] f3, input logic [4:0] rd);
		return {imm, rs1, f3, rd, OP_IMM};
	endfunction

	function automatic logic [31:0] upper_inst(input logic [19:0] imm, input logic [4:0] rd,
		input opcode_e opc);
		return {imm, rd, opc};
	endfunction

	// random OP with a funct7 legal for its funct3
	function automatic logic [31:0] rand_op(input logic [4:0] rs1, input logic [4:0] rd);
		logic [31:0] r;
		logic [6:0]  f7;
		r  = next_rand();
		f7 = ((r[2:0] == 3'd0 || r[2:0] == 3'd5) && r[3]) ? 7'h20 : 7'h00;
		return op_inst(f7, r[8:4], rs1, r[2:0], rd);
	endfunction

	// random OP-IMM where shifts get a proper shamt field
	function automatic logic [31:0] rand_imm(input logic [4:0] rs1, input logic [4:0] rd);
		logic [31:0] r;
		logic [11:0] imm;
		r = next_rand();
		case (r[2:0])
			3'd1:    imm = {7'h00, r[7:3]};
			3'd5:    imm = {1'b0, r[8], 5'b0, r[7:3]};
			default: imm = r[20:9];
		endcase
		return imm_inst(imm, rs1, r[2:0], rd);
	endfunction

	function automatic logic is_supported(input logic [31:0] inst);
		return inst[6:0] inside {OP, OP_IMM, LUI, AUIPC};
	endfunction

	// result by the RV32I rules with operands from the model registers
	function automatic logic [31:0] model_result(input logic [31:0] inst,
		input logic [31:0] pc);
		logic [31:0] a;
		logic [31:0] b;
		logic [4:0]  sh;
		logic        is_op;
		a     = model_regs[inst[19:15]];
		is_op = (inst[6:0] == OP);
		b     = is_op ? model_regs[inst[24:20]] : {{20{inst[31]}}, inst[31:20]};
		sh    = b[4:0];
		if (inst[6:0] == LUI) return {inst[31:12], 12'h000};
		if (inst[6:0] == AUIPC) return pc + {inst[31:12], 12'h000};
		case (inst[14:12])
			3'd0:    return (is_op && inst[30]) ? a - b : a + b;
			3'd1:    return a << sh;
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			// sra fills the vacated top bits with a[31]
			3'd5:    return inst[30] ? ((a >> sh) | (~(32'hffff_ffff >> sh) & {32{a[31]}}))
				: (a >> sh);
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Finished with errors");
		$fatal(1, "run stopped at the first error");
	endtask

	// drives one instruction on the rising edge and checks it on the falling edge
	task automatic run_inst(input logic [31:0] inst, input logic vld);
		logic [31:0] pc;
		logic [31:0] expected;
		logic        exp_wd;
		pc = next_rand() & 32'hffff_fffc;
		@(posedge clk_i);
		valid_i <= vld;
		inst_i  <= inst;
		pc_i    <= pc;
		@(negedge clk_i);
		exp_wd   = vld && is_supported(inst);
		expected = model_result(inst, pc);
		assert (wd_o == exp_wd) else abort_run($sformatf(
			"Fail at %0d ns: wd_o = %b, expected %b", $time, wd_o, exp_wd));
		if (exp_wd) begin
			assert (wreg_o == inst[11:7]) else abort_run($sformatf(
				"Fail at %0d ns: wreg_o = %0d, expected %0d", $time, wreg_o, inst[11:7]));
			assert (wdata_o == expected) else abort_run($sformatf(
				"Fail at %0d ns: wdata_o = %h, expected %h", $time, wdata_o, expected));
			// lands in the DUT on the next rising edge
			if (inst[11:7] != 5'd0) model_regs[inst[11:7]] = expected;
		end
	endtask

	initial begin
		#(WATCHDOG_NS);
		abort_run("timeout: the run took longer than its instruction count allows");
	end

	// the bound checker counts its failed assertions
	initial begin
		wait (UUT.u_checker.failures != 0);
		abort_run("a protocol assertion in the bound checker failed");
	end

	initial begin
		logic [31:0] r;
		logic [4:0]  rd;
		logic [4:0]  prev_rd;
		foreach (model_regs[i]) model_regs[i] = 32'd0;
		reset_i = 1'b1;
		valid_i = 1'b0;
		// a supported instruction waits behind the low valid_i during reset
		inst_i  = op_inst(7'h00, 5'd2, 5'd1, 3'd0, 5'd3);
		pc_i    = 32'd0;
		prev_rd = 5'd1;
		repeat (5) @(posedge clk_i);
		reset_i <= 1'b0;

		// seed every register with lui or auipc
		for (int i = 1; i < 32; i++) begin
			r = next_rand();
			run_inst(upper_inst(r[19:0], 5'(i), r[20] ? LUI : AUIPC), 1'b1);
		end
		repeat (OP_COUNT) begin
			r = next_rand();
			run_inst(rand_op(r[4:0], r[9:5]), 1'b1);
		end
		repeat (IMM_COUNT) begin
			r = next_rand();
			run_inst(rand_imm(r[4:0], r[9:5]), 1'b1);
		end
		// each one reads the register written just before
		repeat (CHAIN_COUNT) begin
			r  = next_rand();
			rd = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
			if (r[5]) run_inst(rand_op(prev_rd, rd), 1'b1);
			else run_inst(rand_imm(prev_rd, rd), 1'b1);
			prev_rd = rd;
		end

		// addi x0 then read x0 back
		run_inst(imm_inst(12'h7ff, 5'd5, 3'd0, 5'd0), 1'b1);
		run_inst(op_inst(7'h00, 5'd0, 5'd0, 3'd0, 5'd9), 1'b1);
		run_inst(op_inst(7'h00, 5'd0, 5'd5, 3'd6, 5'd10), 1'b1);
		// lw is not supported here
		run_inst(32'h00a2_a283, 1'b1);
		run_inst(rand_op(5'd3, 5'd4), 1'b0);
		run_inst(op_inst(7'h20, 5'd2, 5'd1, 3'd5, 5'd11), 1'b1);

		@(posedge clk_i);
		valid_i <= 1'b0;
		@(negedge clk_i);
		if (UUT.u_checker.failures == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: files.f
hw/rv_pkg.sv
hw/exe_ctrl_if.sv
hw/rv_alu.sv
hw/rv_decoder.sv
hw/rv_regfile.sv
hw/rv_exe.sv
hw/rv_exec_top.sv
test/rv_exec_checker.sv
test/rv_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run with Verilator; the pass message in the output decides the status
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module rv_exec_tb -f files.f -Mdir obj_dir ||
{ echo "build failed"; exit 1; }
./obj_dir/Vrv_exec_tb | tee /dev/stderr | grep -q "Finished with no errors" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
